/* Makefile */
TOP := pipelined_processor_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check sim.log"
	@echo "  clean  remove obj_dir and sim.log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f pipelined_processor.f --top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q ">>> FAIL" sim.log || ! grep -q ">>> PASS" sim.log; then \
		echo "Simulation failed"; exit 1; fi
	@echo "Simulation passed"

clean:
	rm -rf obj_dir sim.log

/* pipelined_processor.f */
+incdir+test
source/cpu_pkg.sv
source/prog_apb_slave.sv
source/instr_mem.sv
source/reg_file.sv
source/alu.sv
source/pipeline_core.sv
source/pipelined_processor.sv
test/pipelined_processor_tb.sv

/* source/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::opcode_t op,
    input  logic [15:0]      a,
    input  logic [15:0]      b,
    input  logic             carry_in,
    output logic [15:0]      y,
    output logic             carry_out
);
    import cpu_pkg::*;

    logic [16:0] sum;
    logic [16:0] diff;

    // Bit 16 is the carry, or the borrow for SUB
    assign sum  = {1'b0, a} + {1'b0, b};
    assign diff = {1'b0, a} - {1'b0, b};

    always_comb begin
        y         = '0;
        carry_out = carry_in;
        case (op)
            ADD: begin
                y         = sum[15:0];
                carry_out = sum[16];
            end
            SUB: begin
                y         = diff[15:0];
                carry_out = diff[16];
            end
            AND:  y = a & b;
            // NOT works on the destination register
            NOT:  y = ~a;
            // Immediate arrives on b
            LDM:  y = b;
            SETC: carry_out = 1'b1;
            default: ;
        endcase
    end

    a_y_known: assert final ($isunknown(op) || !$isunknown(y));

endmodule

/* source/cpu_pkg.sv */
package cpu_pkg;

    // Opcode field, bits 15..11 of every instruction word
    typedef enum logic [4:0] {
        NOP  = 5'b00000,
        SETC = 5'b00001,
        HLT  = 5'b00010,
        NOT  = 5'b00011,
        SUB  = 5'b00101,
        AND  = 5'b00110,
        LDM  = 5'b01110,
        ADD  = 5'b11001
    } opcode_t;

    // Instruction word layout, low five bits unused
    typedef struct packed {
        opcode_t    opcode;
        logic [2:0] rdst;
        logic [2:0] rsrc;
        logic [4:0] unused;
    } instr_t;

    // Result handed from execute to writeback
    typedef struct packed {
        logic        we;
        logic [2:0]  rdst;
        logic [15:0] value;
        logic        carry_we;
        logic        carry;
    } exec_result_t;

    // APB request from the host
    typedef struct packed {
        logic        psel;
        logic        penable;
        logic        pwrite;
        logic [11:0] paddr;
        logic [15:0] pwdata;
    } apb_req_t;

    // APB response back to the host
    typedef struct packed {
        logic        pready;
        logic        pslverr;
        logic [15:0] prdata;
    } apb_rsp_t;

    // Host address map
    localparam logic [11:0] addr_imem_base = 12'h000;
    localparam logic [11:0] addr_ctrl      = 12'h400;
    localparam logic [11:0] addr_reg_base  = 12'h480;
    localparam logic [11:0] addr_status    = 12'h4C0;

endpackage

/* source/instr_mem.sv */
`timescale 1ns/1ps

module instr_mem #(
    parameter int imem_depth = 256
) (
    input  logic                          clk,
    input  logic                          we,
    input  logic [$clog2(imem_depth)-1:0] waddr,
    input  logic [15:0]                   wdata,
    input  logic [$clog2(imem_depth)-1:0] raddr,
    output logic [15:0]                   rdata
);

    // Program storage
    logic [15:0] mem [imem_depth];

    // Host write port
    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
    end

    // Registered read gives the one cycle fetch latency
    always_ff @(posedge clk) begin
        rdata <= mem[raddr];
    end

endmodule

/* source/pipeline_core.sv */
`timescale 1ns/1ps

module pipeline_core #(
    parameter int imem_depth = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          run,
    output logic [$clog2(imem_depth)-1:0] fetch_addr,
    input  logic [15:0]                   fetch_data,
    output logic [2:0]                    ra_idx,
    output logic [2:0]                    rb_idx,
    input  logic [15:0]                   ra_data,
    input  logic [15:0]                   rb_data,
    output cpu_pkg::opcode_t              alu_op,
    output logic [15:0]                   alu_a,
    output logic [15:0]                   alu_b,
    output logic                          alu_carry_in,
    input  logic [15:0]                   alu_y,
    input  logic                          alu_carry_out,
    output cpu_pkg::exec_result_t         wb,
    output logic                          carry,
    output logic                          halted
);
    import cpu_pkg::*;

    logic [$clog2(imem_depth)-1:0] pc;
    logic                          fetch_valid;
    logic                          ldm_pending;
    logic [2:0]                    ldm_rdst;
    instr_t                        instr;
    logic                          is_instr;
    logic                          is_imm;
    logic                          halt_now;
    logic                          writes_reg;
    logic                          writes_carry;
    logic [15:0]                   fwd_b;
    exec_result_t                  ex_res;

    assign fetch_addr = pc;
    assign instr      = instr_t'(fetch_data);

    // Word in execute is either an instruction or an LDM immediate
    assign is_imm   = fetch_valid && run && ldm_pending;
    assign is_instr = fetch_valid && run && !ldm_pending;
    assign halt_now = is_instr && (instr.opcode == HLT);

    // Fetch and halt control where run low parks everything at address 0
    always_ff @(posedge clk) begin
        if (reset || !run) begin
            pc          <= '0;
            fetch_valid <= 1'b0;
            ldm_pending <= 1'b0;
            halted      <= 1'b0;
        end else begin
            // Word fetched alongside HLT is dropped
            fetch_valid <= !halted && !halt_now;
            if (!halted && !halt_now) begin
                pc <= pc + 1'b1;
            end
            if (halt_now) begin
                halted <= 1'b1;
            end
            ldm_pending <= is_instr && (instr.opcode == LDM);
        end
    end

    // Destination kept for the immediate word
    always_ff @(posedge clk) begin
        if (is_instr && instr.opcode == LDM) begin
            ldm_rdst <= instr.rdst;
        end
    end

    // Rdst is also operand a
    assign ra_idx = instr.rdst;
    assign rb_idx = instr.rsrc;

    // Writeback to execute bypass
    assign alu_a = (wb.we && wb.rdst == ra_idx) ? wb.value : ra_data;
    assign fwd_b = (wb.we && wb.rdst == rb_idx) ? wb.value : rb_data;
    assign alu_b = is_imm ? fetch_data : fwd_b;
    assign alu_carry_in = wb.carry_we ? wb.carry : carry;

    // Bubbles run through the ALU as NOP
    assign alu_op = is_imm ? LDM : (is_instr ? instr.opcode : NOP);

    always_comb begin
        writes_reg   = 1'b0;
        writes_carry = 1'b0;
        case (instr.opcode)
            ADD, SUB, AND, NOT: begin
                writes_reg   = 1'b1;
                writes_carry = 1'b1;
            end
            SETC: writes_carry = 1'b1;
            default: ;
        endcase
    end

    always_comb begin
        ex_res.we       = is_imm || (is_instr && writes_reg);
        ex_res.rdst     = is_imm ? ldm_rdst : instr.rdst;
        ex_res.value    = alu_y;
        ex_res.carry_we = is_instr && writes_carry;
        ex_res.carry    = alu_carry_out;
    end

    // Writeback register and committed carry
    always_ff @(posedge clk) begin
        if (reset) begin
            wb    <= '0;
            carry <= 1'b0;
        end else begin
            wb <= ex_res;
            if (wb.carry_we) begin
                carry <= wb.carry;
            end
        end
    end

    a_no_write_halted: assert property (@(posedge clk) disable iff (reset)
        halted |-> !wb.we && !wb.carry_we);

    // Immediate word is really in execute and follows a single LDM cycle
    a_ldm_one_word: assert property (@(posedge clk) disable iff (reset)
        ldm_pending |-> fetch_valid && !$past(ldm_pending));

endmodule

/* source/pipelined_processor.sv */
`timescale 1ns/1ps

module pipelined_processor #(
    parameter int imem_depth = 256
) (
    input  logic              clk,
    input  logic              reset,
    input  cpu_pkg::apb_req_t apb_req,
    output cpu_pkg::apb_rsp_t apb_rsp
);
    import cpu_pkg::*;

    // Host side
    logic                          imem_we;
    logic [$clog2(imem_depth)-1:0] imem_addr;
    logic [15:0]                   imem_wdata;
    logic                          run;
    logic [2:0]                    dbg_reg_idx;
    logic [15:0]                   dbg_reg_data;
    logic                          carry;
    logic                          halted;

    // Fetch
    logic [$clog2(imem_depth)-1:0] fetch_addr;
    logic [15:0]                   fetch_data;

    // Register reads
    logic [2:0]                    ra_idx;
    logic [2:0]                    rb_idx;
    logic [15:0]                   ra_data;
    logic [15:0]                   rb_data;

    // ALU
    opcode_t                       alu_op;
    logic [15:0]                   alu_a;
    logic [15:0]                   alu_b;
    logic                          alu_carry_in;
    logic [15:0]                   alu_y;
    logic                          alu_carry_out;

    exec_result_t                  wb;

    prog_apb_slave #(
        .imem_depth(imem_depth)
    ) prog_apb_slave_inst (
        .clk         (clk),
        .reset       (reset),
        .apb_req     (apb_req),
        .apb_rsp     (apb_rsp),
        .imem_we     (imem_we),
        .imem_addr   (imem_addr),
        .imem_wdata  (imem_wdata),
        .run         (run),
        .dbg_reg_idx (dbg_reg_idx),
        .dbg_reg_data(dbg_reg_data),
        .carry       (carry),
        .halted      (halted)
    );

    instr_mem #(
        .imem_depth(imem_depth)
    ) instr_mem_inst (
        .clk  (clk),
        .we   (imem_we),
        .waddr(imem_addr),
        .wdata(imem_wdata),
        .raddr(fetch_addr),
        .rdata(fetch_data)
    );

    reg_file reg_file_inst (
        .clk     (clk),
        .reset   (reset),
        .ra_idx  (ra_idx),
        .rb_idx  (rb_idx),
        .ra_data (ra_data),
        .rb_data (rb_data),
        .dbg_idx (dbg_reg_idx),
        .dbg_data(dbg_reg_data),
        .wr      (wb)
    );

    alu alu_inst (
        .op       (alu_op),
        .a        (alu_a),
        .b        (alu_b),
        .carry_in (alu_carry_in),
        .y        (alu_y),
        .carry_out(alu_carry_out)
    );

    pipeline_core #(
        .imem_depth(imem_depth)
    ) pipeline_core_inst (
        .clk          (clk),
        .reset        (reset),
        .run          (run),
        .fetch_addr   (fetch_addr),
        .fetch_data   (fetch_data),
        .ra_idx       (ra_idx),
        .rb_idx       (rb_idx),
        .ra_data      (ra_data),
        .rb_data      (rb_data),
        .alu_op       (alu_op),
        .alu_a        (alu_a),
        .alu_b        (alu_b),
        .alu_carry_in (alu_carry_in),
        .alu_y        (alu_y),
        .alu_carry_out(alu_carry_out),
        .wb           (wb),
        .carry        (carry),
        .halted       (halted)
    );

endmodule

/* source/prog_apb_slave.sv */
`timescale 1ns/1ps

module prog_apb_slave #(
    parameter int imem_depth = 256
) (
    input  logic                          clk,
    input  logic                          reset,
    input  cpu_pkg::apb_req_t             apb_req,
    output cpu_pkg::apb_rsp_t             apb_rsp,
    output logic                          imem_we,
    output logic [$clog2(imem_depth)-1:0] imem_addr,
    output logic [15:0]                   imem_wdata,
    output logic                          run,
    output logic [2:0]                    dbg_reg_idx,
    input  logic [15:0]                   dbg_reg_data,
    input  logic                          carry,
    input  logic                          halted
);
    import cpu_pkg::*;

    localparam int addr_w = $clog2(imem_depth);

    // Bus phase seen in the previous cycle
    typedef enum logic [1:0] {
        s_idle,
        s_setup,
        s_access
    } apb_state_t;

    apb_state_t  state;
    logic        access;
    logic        hit_imem;
    logic        hit_ctrl;
    logic        hit_reg;
    logic        hit_status;
    logic        err;
    logic [15:0] rdata;

    // Setup last cycle plus enable now means access phase
    assign access = (state == s_setup) && apb_req.psel && apb_req.penable;

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= s_idle;
        end else if (apb_req.psel && !apb_req.penable) begin
            state <= s_setup;
        end else if (access) begin
            state <= s_access;
        end else begin
            state <= s_idle;
        end
    end

    // Address decode
    assign hit_imem   = int'(apb_req.paddr - addr_imem_base) < imem_depth;
    assign hit_ctrl   = apb_req.paddr == addr_ctrl;
    assign hit_reg    = apb_req.paddr[11:3] == addr_reg_base[11:3];
    assign hit_status = apb_req.paddr == addr_status;

    // Error on unmapped, read-only written, write-only read or program locked while running
    assign err = !(hit_imem || hit_ctrl || hit_reg || hit_status)
               || (apb_req.pwrite && (hit_reg || hit_status))
               || (hit_imem && (!apb_req.pwrite || run));

    // Run bit can be written at any time
    always_ff @(posedge clk) begin
        if (reset) begin
            run <= 1'b0;
        end else if (access && apb_req.pwrite && hit_ctrl) begin
            run <= apb_req.pwdata[0];
        end
    end

    // Program load port
    assign imem_we    = access && apb_req.pwrite && hit_imem && !run;
    assign imem_addr  = apb_req.paddr[addr_w-1:0];
    assign imem_wdata = apb_req.pwdata;

    assign dbg_reg_idx = apb_req.paddr[2:0];

    always_comb begin
        rdata = '0;
        if (hit_ctrl) begin
            rdata = {15'b0, run};
        end else if (hit_reg) begin
            rdata = dbg_reg_data;
        end else if (hit_status) begin
            rdata = {14'b0, halted, carry};
        end
    end

    // Zero wait states so the response comes only in the access cycle
    always_comb begin
        apb_rsp.pready  = access;
        apb_rsp.pslverr = access && err;
        apb_rsp.prdata  = (access && !apb_req.pwrite) ? rdata : '0;
    end

    // Pready only right after exactly one setup cycle
    a_pready_in_access: assert property (@(posedge clk) disable iff (reset)
        apb_rsp.pready |-> apb_req.psel && apb_req.penable
                           && $past(apb_req.psel && !apb_req.penable));

    // A program write is a completed error-free access with the core stopped
    a_no_load_while_running: assert property (@(posedge clk) disable iff (reset)
        imem_we |-> !run && apb_rsp.pready && !apb_rsp.pslverr);

endmodule

/* source/reg_file.sv */
`timescale 1ns/1ps

module reg_file (
    input  logic                  clk,
    input  logic                  reset,
    input  logic [2:0]            ra_idx,
    input  logic [2:0]            rb_idx,
    output logic [15:0]           ra_data,
    output logic [15:0]           rb_data,
    input  logic [2:0]            dbg_idx,
    output logic [15:0]           dbg_data,
    input  cpu_pkg::exec_result_t wr
);

    // R0 to R7
    logic [15:0] regs [8];

    // Single write port fed by writeback
    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < 8; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.we) begin
            regs[wr.rdst] <= wr.value;
        end
    end

    // Execute operands, same-cycle writes come through the core bypass
    assign ra_data = regs[ra_idx];
    assign rb_data = regs[rb_idx];

    // Host debug view
    assign dbg_data = regs[dbg_idx];

endmodule

/* test/apb_host_tasks.svh */
`ifndef apb_host_tasks_svh
`define apb_host_tasks_svh

// One transfer, setup cycle then access cycle until pready
task automatic apb_access(input logic write, input logic [11:0] addr,
                          input logic [15:0] wdata, output logic [15:0] rdata,
                          output logic err);
    int waited;
    rdata = '0;
    err   = 1'b1;
    @(posedge clk);
    #1;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    apb_req.pwrite  = write;
    apb_req.paddr   = addr;
    apb_req.pwdata  = wdata;
    @(posedge clk);
    #1;
    apb_req.penable = 1'b1;
    // Response is looked at mid cycle
    waited = 0;
    @(negedge clk);
    while (!apb_rsp.pready && waited < ready_limit) begin
        @(negedge clk);
        waited++;
    end
    if (!apb_rsp.pready) begin
        stop_on_timeout($sformatf("no pready for address %h", addr));
    end else begin
        rdata = apb_rsp.prdata;
        err   = apb_rsp.pslverr;
        @(posedge clk);
        #1;
        apb_req = '0;
    end
endtask

task automatic apb_write(input logic [11:0] addr, input logic [15:0] data,
                         output logic err);
    logic [15:0] ignored;
    apb_access(1'b1, addr, data, ignored, err);
endtask

task automatic apb_read(input logic [11:0] addr, output logic [15:0] data,
                        output logic err);
    apb_access(1'b0, addr, 16'h0000, data, err);
endtask

// Word n of the queue goes to instruction address n
task automatic load_program();
    logic err;
    foreach (prog[i]) begin
        apb_write(addr_imem_base + 12'(i), prog[i], err);
        check_value($sformatf("load word %0d error", i), 16'h0000, {15'b0, err});
    end
endtask

`endif

/* test/pipelined_processor_tb.sv */
`timescale 1ns/1ps

module pipelined_processor_tb;
    import cpu_pkg::*;

    localparam int imem_depth  = 256;
    localparam int ready_limit = 8;
    localparam int halt_limit  = 200;

    logic     clk;
    logic     reset;
    apb_req_t apb_req;
    apb_rsp_t apb_rsp;

    // Expected architectural state, stepped as the program is built
    logic [15:0] model_regs [8];
    logic        model_carry;
    logic [15:0] prog [$];

    integer seed;
    int     check_errors;
    int     errors_before;
    int     tests_run;
    int     tests_failed;
    string  test_name;

    pipelined_processor #(
        .imem_depth(imem_depth)
    ) pipelined_processor_inst (
        .clk    (clk),
        .reset  (reset),
        .apb_req(apb_req),
        .apb_rsp(apb_rsp)
    );

    // 100 ns period
    always #50 clk = ~clk;

    // Error response only together with pready
    a_err_with_ready: assert property (@(posedge clk) disable iff (reset)
        apb_rsp.pslverr |-> apb_rsp.pready)
        else begin
            $display("In %s pslverr was high outside an access cycle", test_name);
            check_errors++;
        end

    task automatic stop_on_timeout(input string what);
        $display("Timeout in %s: %s", test_name, what);
        $display(">>> FAIL");
        $finish;
    endtask

    task automatic check_value(input string what, input logic [15:0] expected,
                               input logic [15:0] actual);
        assert (actual === expected)
        else begin
            $display("CHECK FAILED %s: %s expected %h actual %h",
                     test_name, what, expected, actual);
            check_errors++;
        end
    endtask

    `include "apb_host_tasks.svh"

    // LDM is two words, the immediate lands in rd
    task automatic emit_ldm(input logic [2:0] rd, input logic [15:0] imm);
        prog.push_back({LDM, rd, 3'b000, 5'b00000});
        prog.push_back(imm);
        model_regs[rd] = imm;
    endtask

    // One-word instruction plus its effect on the expected state
    task automatic emit_op(input opcode_t op, input logic [2:0] rd, input logic [2:0] rs);
        int a;
        int b;
        int total;
        a = int'(model_regs[rd]);
        b = int'(model_regs[rs]);
        prog.push_back({op, rd, rs, 5'b00000});
        case (op)
            ADD: begin
                total = a + b;
                model_regs[rd] = total[15:0];
                // Anything past 16 bits is a carry
                model_carry = total > 65535;
            end
            SUB: begin
                total = a - b;
                model_regs[rd] = total[15:0];
                // Borrow when the subtrahend is larger
                model_carry = a < b;
            end
            AND: model_regs[rd] = model_regs[rd] & model_regs[rs];
            NOT: model_regs[rd] = ~model_regs[rd];
            SETC: model_carry = 1'b1;
            default: ;
        endcase
    endtask

    // Stop, optionally reload, start, wait for halt, compare state
    task automatic run_program(input bit reload);
        logic [15:0] data;
        logic        err;
        int          polls;
        apb_write(addr_ctrl, 16'h0000, err);
        check_value("run clear error", 16'h0000, {15'b0, err});
        if (reload) begin
            load_program();
        end
        apb_write(addr_ctrl, 16'h0001, err);
        check_value("run set error", 16'h0000, {15'b0, err});
        polls = 0;
        data  = '0;
        while (!data[1] && polls < halt_limit) begin
            apb_read(addr_status, data, err);
            polls++;
        end
        if (!data[1]) begin
            stop_on_timeout("core never reported halted");
        end else begin
            check_value("carry", {15'b0, model_carry}, {15'b0, data[0]});
            for (int r = 0; r < 8; r++) begin
                apb_read(addr_reg_base + 12'(r), data, err);
                check_value($sformatf("R%0d", r), model_regs[r], data);
            end
        end
    endtask

    task automatic start_test(input string name);
        test_name     = name;
        errors_before = check_errors;
        prog.delete();
    endtask

    task automatic end_test();
        tests_run++;
        if (check_errors != errors_before) begin
            tests_failed++;
            $display("test %s failed", test_name);
        end else begin
            $display("test %s passed", test_name);
        end
    endtask

    initial begin
        logic [15:0] x;
        logic [15:0] y;
        logic [15:0] data;
        logic        err;
        clk          = 1'b0;
        reset        = 1'b1;
        apb_req      = '0;
        seed         = 32'h2d8a;
        check_errors = 0;
        tests_run    = 0;
        tests_failed = 0;
        test_name    = "reset";
        for (int r = 0; r < 8; r++) begin
            model_regs[r] = '0;
        end
        model_carry = 1'b0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;

        start_test("ldm_immediates");
        for (int r = 1; r < 8; r++) begin
            emit_ldm(3'(r), 16'($random(seed)));
        end
        emit_op(HLT, 3'd0, 3'd0);
        run_program(1'b1);
        end_test();

        // Each op uses the result right before it, so operands come from the bypass
        start_test("add_sub_bypass");
        for (int k = 0; k < 4; k++) begin
            prog.delete();
            emit_ldm(3'd1, 16'($random(seed)));
            emit_ldm(3'd2, 16'($random(seed)));
            emit_op(ADD, 3'd1, 3'd2);
            emit_op(SUB, 3'd2, 3'd1);
            // Odd runs end on ADD, even runs on SUB
            if (k[0]) begin
                emit_op(ADD, 3'd2, 3'd1);
            end
            emit_op(HLT, 3'd0, 3'd0);
            run_program(1'b1);
        end
        end_test();

        start_test("logic_and_setc");
        emit_ldm(3'd4, 16'($random(seed)));
        emit_ldm(3'd5, 16'($random(seed)));
        emit_op(AND, 3'd4, 3'd5);
        emit_op(NOT, 3'd5, 3'd0);
        // Zero result clears carry so SETC has something to do
        emit_op(SUB, 3'd6, 3'd6);
        emit_op(SETC, 3'd0, 3'd0);
        emit_op(NOT, 3'd4, 3'd0);
        emit_op(HLT, 3'd0, 3'd0);
        run_program(1'b1);
        end_test();

        start_test("halt_stops_fetch");
        x = 16'($random(seed));
        y = 16'($random(seed));
        emit_ldm(3'd1, x);
        emit_ldm(3'd2, y);
        emit_op(ADD, 3'd1, 3'd2);
        emit_op(HLT, 3'd0, 3'd0);
        // Never reached, so the model stays put
        prog.push_back({LDM, 3'd3, 3'd0, 5'd0});
        prog.push_back(~x);
        prog.push_back({NOT, 3'd1, 3'd0, 5'd0});
        prog.push_back({SETC, 3'd0, 3'd0, 5'd0});
        run_program(1'b1);
        apb_read(addr_status, data, err);
        check_value("halted", 16'h0001, {15'b0, data[1]});
        end_test();

        // Run is still set from the halted program above
        start_test("apb_errors");
        apb_write(addr_imem_base + 12'd1, ~x, err);
        check_value("imem write while running", 16'h0001, {15'b0, err});
        apb_read(12'h7FF, data, err);
        check_value("unmapped read", 16'h0001, {15'b0, err});
        apb_write(addr_status, 16'h0003, err);
        check_value("status write", 16'h0001, {15'b0, err});
        // Same program again, same results if memory was left alone
        run_program(1'b0);
        end_test();

        $display("tests run %0d, failed %0d, check failures %0d",
                 tests_run, tests_failed, check_errors);
        if (check_errors == 0 && tests_failed == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

endmodule
